// File: hw/alu_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module alu_unit (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              issue_accept,
    input  wire isa_pkg::alu_op_t  issue_op,
    input  wire rob_pkg::rob_tag_t issue_tag,
    input  wire isa_pkg::data_t    issue_a,
    input  wire isa_pkg::data_t    issue_b,
    output logic                   alu_done,
    output rob_pkg::rob_tag_t      alu_tag,
    output isa_pkg::data_t         alu_value
);

    logic           is_alu_op;
    isa_pkg::data_t result;

    // ALU class only, multiplies go elsewhere
    always_comb begin
        is_alu_op = 1'b1;
        result    = '0;
        case (issue_op)
            isa_pkg::OP_ADD: result = issue_a + issue_b;
            isa_pkg::OP_SUB: result = issue_a - issue_b;
            isa_pkg::OP_AND: result = issue_a & issue_b;
            isa_pkg::OP_OR:  result = issue_a | issue_b;
            isa_pkg::OP_XOR: result = issue_a ^ issue_b;
            isa_pkg::OP_SLL: result = issue_a << issue_b[4:0];
            isa_pkg::OP_SRL: result = issue_a >> issue_b[4:0];
            isa_pkg::OP_SLT: begin
                result = {{(`XLEN-1){1'b0}}, ($signed(issue_a) < $signed(issue_b))};
            end
            default: is_alu_op = 1'b0;
        endcase
    end

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            alu_done <= 1'b0;
        end else begin
            alu_done <= issue_accept && is_alu_op;   // single pulse
        end
    end

    always_ff @(posedge clk) begin
        if (issue_accept && is_alu_op) begin
            alu_tag   <= issue_tag;
            alu_value <= result;
        end
    end

endmodule

`default_nettype wire

// File: hw/core_params.svh
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// datapath widths
`define XLEN        32
`define REG_IDX_W   5

// reorder buffer
`define ROB_DEPTH   4
`define ROB_TAG_W   2   // enough bits to number every slot

// multiplier latency in cycles
`define MUL_STAGES  6

`endif

// File: hw/exec_core.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module exec_core (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              issue_valid,
    input  wire isa_pkg::alu_op_t  issue_op,
    input  wire isa_pkg::reg_idx_t issue_rd,
    input  wire isa_pkg::data_t    issue_a,
    input  wire isa_pkg::data_t    issue_b,
    output logic                   rob_full,
    output logic                   commit_valid,
    output isa_pkg::reg_idx_t      commit_rd,
    output isa_pkg::data_t         commit_value
);

    logic              issue_accept;
    rob_pkg::rob_tag_t issue_tag;

    // result buses back to the reorder buffer
    logic              alu_done;
    rob_pkg::rob_tag_t alu_tag;
    isa_pkg::data_t    alu_value;
    logic              mul_done;
    rob_pkg::rob_tag_t mul_tag;
    isa_pkg::data_t    mul_value;

    reorder_buffer u_reorder_buffer (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_rd     (issue_rd),
        .alu_done     (alu_done),
        .alu_tag      (alu_tag),
        .alu_value    (alu_value),
        .mul_done     (mul_done),
        .mul_tag      (mul_tag),
        .mul_value    (mul_value),
        .issue_accept (issue_accept),
        .issue_tag    (issue_tag),
        .rob_full     (rob_full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    alu_unit u_alu_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_accept (issue_accept),
        .issue_op     (issue_op),
        .issue_tag    (issue_tag),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .alu_done     (alu_done),
        .alu_tag      (alu_tag),
        .alu_value    (alu_value)
    );

    mul_unit #(
        .STAGES (`MUL_STAGES)
    ) u_mul_unit (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_accept (issue_accept),
        .issue_op     (issue_op),
        .issue_tag    (issue_tag),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .mul_done     (mul_done),
        .mul_tag      (mul_tag),
        .mul_value    (mul_value)
    );

endmodule

`default_nettype wire

// File: hw/isa_pkg.sv
`default_nettype none

`include "core_params.svh"

package isa_pkg;

    typedef logic [`XLEN-1:0]      data_t;
    typedef logic [`REG_IDX_W-1:0] reg_idx_t;   // destination register number

    // fixed encodings 0 to 9
    typedef enum logic [3:0] {
        OP_ADD   = 4'd0,
        OP_SUB   = 4'd1,
        OP_AND   = 4'd2,
        OP_OR    = 4'd3,
        OP_XOR   = 4'd4,
        OP_SLL   = 4'd5,
        OP_SRL   = 4'd6,
        OP_SLT   = 4'd7,
        OP_MUL   = 4'd8,   // low word
        OP_MULHU = 4'd9    // high word, unsigned
    } alu_op_t;

endpackage

`default_nettype wire

// File: hw/mul_unit.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module mul_unit #(
    parameter int STAGES = `MUL_STAGES
) (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              issue_accept,
    input  wire isa_pkg::alu_op_t  issue_op,
    input  wire rob_pkg::rob_tag_t issue_tag,
    input  wire isa_pkg::data_t    issue_a,
    input  wire isa_pkg::data_t    issue_b,
    output logic                   mul_done,
    output rob_pkg::rob_tag_t      mul_tag,
    output isa_pkg::data_t         mul_value
);

    logic                   mul_start;
    logic [2*`XLEN-1:0]     product;

    logic [STAGES-1:0]      vld_q;
    rob_pkg::rob_tag_t      tag_q  [STAGES];
    logic                   hi_q   [STAGES];   // mulhu selects the upper word
    logic [2*`XLEN-1:0]     prod_q [STAGES];

    assign mul_start = issue_accept &&
                       (issue_op == isa_pkg::OP_MUL || issue_op == isa_pkg::OP_MULHU);

    // full unsigned product
    assign product = {{`XLEN{1'b0}}, issue_a} * {{`XLEN{1'b0}}, issue_b};

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            vld_q <= '0;
        end else begin
            vld_q[0] <= mul_start;
            for (int i = 1; i < STAGES; i++) begin
                vld_q[i] <= vld_q[i-1];
            end
        end
    end

    // payload shifts every cycle so a new op can enter each cycle
    always_ff @(posedge clk) begin
        tag_q[0]  <= issue_tag;
        hi_q[0]   <= (issue_op == isa_pkg::OP_MULHU);
        prod_q[0] <= product;
        for (int i = 1; i < STAGES; i++) begin
            tag_q[i]  <= tag_q[i-1];
            hi_q[i]   <= hi_q[i-1];
            prod_q[i] <= prod_q[i-1];
        end
    end

    assign mul_done  = vld_q[STAGES-1];
    assign mul_tag   = tag_q[STAGES-1];
    assign mul_value = hi_q[STAGES-1] ? prod_q[STAGES-1][2*`XLEN-1:`XLEN]
                                      : prod_q[STAGES-1][`XLEN-1:0];

endmodule

`default_nettype wire

// File: hw/reorder_buffer.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module reorder_buffer (
    input  wire logic              clk,
    input  wire logic              arst_n,
    input  wire logic              issue_valid,
    input  wire isa_pkg::reg_idx_t issue_rd,
    input  wire logic              alu_done,
    input  wire rob_pkg::rob_tag_t alu_tag,
    input  wire isa_pkg::data_t    alu_value,
    input  wire logic              mul_done,
    input  wire rob_pkg::rob_tag_t mul_tag,
    input  wire isa_pkg::data_t    mul_value,
    output logic                   issue_accept,
    output rob_pkg::rob_tag_t      issue_tag,
    output logic                   rob_full,
    output logic                   commit_valid,
    output isa_pkg::reg_idx_t      commit_rd,
    output isa_pkg::data_t         commit_value
);

    rob_pkg::entry_state_t state_q [`ROB_DEPTH];
    isa_pkg::reg_idx_t     rd_q    [`ROB_DEPTH];
    isa_pkg::data_t        value_q [`ROB_DEPTH];

    rob_pkg::rob_tag_t     head_q;
    rob_pkg::rob_tag_t     tail_q;
    logic [`ROB_TAG_W:0]   count_q;   // one extra bit to hold a full count

    logic                  commit_ready;

    assign rob_full     = (count_q == (`ROB_TAG_W+1)'(`ROB_DEPTH));
    assign issue_accept = issue_valid && !rob_full;
    assign issue_tag    = tail_q;
    assign commit_ready = (state_q[head_q] == rob_pkg::ENTRY_DONE);

    // control state: entry states, pointers, count
    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            for (int i = 0; i < `ROB_DEPTH; i++) begin
                state_q[i] <= rob_pkg::ENTRY_FREE;
            end
            head_q       <= '0;
            tail_q       <= '0;
            count_q      <= '0;
            commit_valid <= 1'b0;
        end else begin
            if (issue_accept) begin
                state_q[tail_q] <= rob_pkg::ENTRY_WAIT;
                tail_q <= (tail_q == rob_pkg::rob_tag_t'(`ROB_DEPTH-1)) ? '0 : tail_q + 1'b1;
            end

            // both units may write back in the same cycle
            if (alu_done) begin
                state_q[alu_tag] <= rob_pkg::ENTRY_DONE;
            end
            if (mul_done) begin
                state_q[mul_tag] <= rob_pkg::ENTRY_DONE;
            end

            if (commit_ready) begin
                state_q[head_q] <= rob_pkg::ENTRY_FREE;
                head_q <= (head_q == rob_pkg::rob_tag_t'(`ROB_DEPTH-1)) ? '0 : head_q + 1'b1;
            end
            commit_valid <= commit_ready;   // one pulse per retired entry

            case ({issue_accept, commit_ready})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // entry payload
    always_ff @(posedge clk) begin
        if (issue_accept) begin
            rd_q[tail_q] <= issue_rd;
        end
        if (alu_done) begin
            value_q[alu_tag] <= alu_value;
        end
        if (mul_done) begin
            value_q[mul_tag] <= mul_value;
        end
        if (commit_ready) begin
            commit_rd    <= rd_q[head_q];
            commit_value <= value_q[head_q];
        end
    end

endmodule

`default_nettype wire

// File: hw/rob_pkg.sv
`default_nettype none

`include "core_params.svh"

package rob_pkg;

    // slot number, handed out at issue and returned with the result
    typedef logic [`ROB_TAG_W-1:0] rob_tag_t;

    typedef enum logic [1:0] {
        ENTRY_FREE = 2'd0,
        ENTRY_WAIT = 2'd1,   // allocated, result pending
        ENTRY_DONE = 2'd2    // result written, ready to retire
    } entry_state_t;

endpackage

`default_nettype wire

// File: run.sh
#!/usr/bin/env bash
# build the exec_core testbench with Verilator and run it
set -e

cd "$(dirname "$0")"

verilator --binary -f tb.f --top-module exec_core_tb -o sim_exec_core

output="$(./obj_dir/sim_exec_core)"
echo "$output"

if echo "$output" | grep -qx "No errors"; then
    echo "simulation passed"
    exit 0
else
    echo "simulation failed"
    exit 1
fi

// File: tb.f
+incdir+hw
hw/isa_pkg.sv
hw/rob_pkg.sv
hw/alu_unit.sv
hw/mul_unit.sv
hw/reorder_buffer.sv
hw/exec_core.sv
verification/exec_core_tb.sv

// File: verification/exec_core_stim.txt
# test op rd a b accept expected, all hex
# op 0-7 ALU, 8 mul, 9 mulhu; accept 0 means presented while full and never commits
2 0 01 00000005 00000003 1 00000008
2 0 02 FFFFFFFF 00000001 1 00000000
2 0 03 12345678 11111111 1 23456789
2 1 04 0000000A 00000003 1 00000007
2 1 05 00000000 00000001 1 FFFFFFFF
2 1 06 80000000 00000001 1 7FFFFFFF
2 2 07 F0F0F0F0 0FF00FF0 1 00F000F0
2 2 08 FFFFFFFF 12345678 1 12345678
2 3 09 F0F0F0F0 0F0F0F0F 1 FFFFFFFF
2 3 0A 12340000 00005678 1 12345678
2 3 0B 00000000 00000000 1 00000000
2 4 0C FFFF0000 0F0F0F0F 1 F0F00F0F
2 4 0D 12345678 12345678 1 00000000
2 4 0E AAAAAAAA 55555555 1 FFFFFFFF
2 5 0F 00000001 00000004 1 00000010
2 5 10 00000001 0000001F 1 80000000
2 5 11 00000003 00000021 1 00000006
2 5 12 12345678 00000008 1 34567800
2 6 13 80000000 0000001F 1 00000001
2 6 14 F0000000 00000004 1 0F000000
2 6 15 12345678 00000024 1 01234567
2 6 16 FFFFFFFF FFFFFFE0 1 FFFFFFFF
2 7 17 FFFFFFFF 00000001 1 00000001
2 7 18 00000001 FFFFFFFF 1 00000000
2 7 19 80000000 7FFFFFFF 1 00000001
2 7 1A 00000005 00000005 1 00000000
2 7 1B FFFFFFF0 FFFFFFFF 1 00000001
3 8 01 FFFFFFFF FFFFFFFF 1 00000001
3 9 02 FFFFFFFF FFFFFFFF 1 FFFFFFFE
3 9 03 80000000 00000002 1 00000001
3 8 04 12345678 00010000 1 56780000
4 9 05 FFFFFFFF 00000002 1 00000001
4 0 06 00000001 00000002 1 00000003
4 4 07 0000FFFF 000000FF 1 0000FF00
4 7 08 FFFFFFFE 00000000 1 00000001
5 8 09 00000003 00000007 1 00000015
5 8 0A 0000FFFF 0000FFFF 1 FFFE0001
5 9 0B FFFFFFFF 00000010 1 0000000F
5 8 0C 00001000 00001000 1 01000000
5 0 0D 00000001 00000001 0 00000000

// File: verification/exec_core_tb.sv
`timescale 1ns/1ns
`default_nettype none

`include "core_params.svh"

module exec_core_tb;

    localparam int    MAX_LINES   = 64;
    localparam int    DRAIN_LIMIT = `ROB_DEPTH * (`MUL_STAGES + 4);   // full buffer retiring
    localparam string STIM_FILE   = "verification/exec_core_stim.txt";

    logic              clk;
    logic              arst_n;
    logic              issue_valid;
    isa_pkg::alu_op_t  issue_op;
    isa_pkg::reg_idx_t issue_rd;
    isa_pkg::data_t    issue_a;
    isa_pkg::data_t    issue_b;
    logic              rob_full;
    logic              commit_valid;
    isa_pkg::reg_idx_t commit_rd;
    isa_pkg::data_t    commit_value;

    // stimulus table, one row per file line
    int                line_count;
    int                stim_test   [MAX_LINES];
    isa_pkg::alu_op_t  stim_op     [MAX_LINES];
    isa_pkg::reg_idx_t stim_rd     [MAX_LINES];
    isa_pkg::data_t    stim_a      [MAX_LINES];
    isa_pkg::data_t    stim_b      [MAX_LINES];
    logic              stim_accept [MAX_LINES];
    isa_pkg::data_t    stim_expect [MAX_LINES];

    // commits still owed by the DUT, oldest first
    isa_pkg::reg_idx_t exp_rd_q    [$];
    isa_pkg::data_t    exp_value_q [$];

    int errors;
    int tests_passed;
    int tests_failed;
    int commit_count;
    int seed;

    initial clk = 1'b0;
    always #5 clk = ~clk;

    exec_core DUT (
        .clk          (clk),
        .arst_n       (arst_n),
        .issue_valid  (issue_valid),
        .issue_op     (issue_op),
        .issue_rd     (issue_rd),
        .issue_a      (issue_a),
        .issue_b      (issue_b),
        .rob_full     (rob_full),
        .commit_valid (commit_valid),
        .commit_rd    (commit_rd),
        .commit_value (commit_value)
    );

    task automatic check_rd(input isa_pkg::reg_idx_t expected, input isa_pkg::reg_idx_t actual);
        if (actual !== expected) begin
            $display("Fail commit_rd expected %h actual %h", expected, actual);
            errors++;
        end
    endtask

    task automatic check_value(input isa_pkg::data_t expected, input isa_pkg::data_t actual);
        if (actual !== expected) begin
            $display("Fail commit_value expected %h actual %h", expected, actual);
            errors++;
        end
    endtask

    task automatic check_full(input logic expected, input string where);
        if (rob_full !== expected) begin
            $display("rob_full is %0b %s but should be %0b", rob_full, where, expected);
            errors++;
        end
    endtask

    task automatic load_stimulus();
        int          fd;
        int          fields;
        string       text;
        logic [31:0] t_raw;
        logic [31:0] op_raw;
        logic [31:0] rd_raw;
        logic [31:0] a_raw;
        logic [31:0] b_raw;
        logic [31:0] acc_raw;
        logic [31:0] exp_raw;
        fd = $fopen(STIM_FILE, "r");
        line_count = 0;
        if (fd == 0) begin
            $display("cannot open stimulus file %s", STIM_FILE);
            errors++;
        end else begin
            while ($fgets(text, fd) != 0) begin
                fields = $sscanf(text, "%h %h %h %h %h %h %h",
                                 t_raw, op_raw, rd_raw, a_raw, b_raw, acc_raw, exp_raw);
                if (text.len() <= 1 || text.substr(0, 0) == "#") begin
                    continue;   // blank or column notes
                end
                if (fields != 7 || line_count >= MAX_LINES) begin
                    $display("stimulus line could not be read: %s", text);
                    errors++;
                end else begin
                    stim_test[line_count]   = int'(t_raw);
                    stim_op[line_count]     = isa_pkg::alu_op_t'(op_raw[3:0]);
                    stim_rd[line_count]     = rd_raw[`REG_IDX_W-1:0];
                    stim_a[line_count]      = a_raw;
                    stim_b[line_count]      = b_raw;
                    stim_accept[line_count] = acc_raw[0];
                    stim_expect[line_count] = exp_raw;
                    line_count++;
                end
            end
            $fclose(fd);
        end
    endtask

    // present one line; the DUT samples it on the next rising edge
    task automatic issue_line(input int idx);
        issue_valid <= 1'b1;
        issue_op    <= stim_op[idx];
        issue_rd    <= stim_rd[idx];
        issue_a     <= stim_a[idx];
        issue_b     <= stim_b[idx];
        if (stim_accept[idx]) begin
            exp_rd_q.push_back(stim_rd[idx]);
            exp_value_q.push_back(stim_expect[idx]);
        end
        @(negedge clk);
        check_full(!stim_accept[idx], $sformatf("while line %0d is presented", idx));
        @(posedge clk);
    endtask

    task automatic idle_cycles(input int n);
        issue_valid <= 1'b0;
        repeat (n) @(posedge clk);
    endtask

    task automatic wait_drain();
        int waited;
        issue_valid <= 1'b0;
        waited = 0;
        while (exp_rd_q.size() != 0 && waited < DRAIN_LIMIT) begin
            @(posedge clk);
            waited++;
        end
        if (exp_rd_q.size() != 0) begin
            $display("%0d expected commits never arrived", exp_rd_q.size());
            errors++;
            exp_rd_q.delete();
            exp_value_q.delete();
        end
        repeat (8) @(posedge clk);   // room for a stray commit to show up
        @(negedge clk);
        check_full(1'b0, "after all commits");
        @(posedge clk);   // next issue starts on a rising edge
    endtask

    task automatic report_test(input int test_id, input int errors_at_start);
        if (errors == errors_at_start) begin
            tests_passed++;
            $display("test %0d passed", test_id);
        end else begin
            tests_failed++;
            $display("test %0d failed with %0d mismatches", test_id, errors - errors_at_start);
        end
    endtask

    // results are stable by the falling edge
    always @(negedge clk) begin
        if (arst_n && commit_valid) begin
            commit_count++;
            if (exp_rd_q.size() == 0) begin
                $display("commit to rd %h arrived when no commit was expected", commit_rd);
                errors++;
            end else begin
                check_rd(exp_rd_q.pop_front(), commit_rd);
                check_value(exp_value_q.pop_front(), commit_value);
            end
        end
    end

    initial begin
        int idx;
        int test_id;
        int gap;
        int errors_at_start;
        int first_of_test;
        seed         = 39945;
        errors       = 0;
        tests_passed = 0;
        tests_failed = 0;
        commit_count = 0;
        arst_n       = 1'b0;
        issue_valid  = 1'b0;
        issue_op     = isa_pkg::OP_ADD;
        issue_rd     = '0;
        issue_a      = '0;
        issue_b      = '0;
        load_stimulus();

        repeat (8) @(posedge clk);
        arst_n <= 1'b1;
        @(posedge clk);

        // test 1: quiet after reset
        errors_at_start = errors;
        @(negedge clk);
        check_full(1'b0, "after reset");
        if (commit_valid !== 1'b0) begin
            $display("commit_valid is high right after reset");
            errors++;
        end
        repeat (12) @(posedge clk);
        if (commit_count != 0) begin
            $display("commits occurred while issue_valid was low");
            errors++;
        end
        report_test(1, errors_at_start);

        idx = 0;
        while (idx < line_count) begin
            test_id         = stim_test[idx];
            errors_at_start = errors;
            first_of_test   = 1;
            while (idx < line_count && stim_test[idx] == test_id) begin
                if (!first_of_test && test_id < 4) begin   // tests 4 and 5 run back to back
                    gap = $unsigned($random(seed)) % 4;
                    if (gap > 0) begin
                        idle_cycles(gap);
                    end
                end
                issue_line(idx);
                first_of_test = 0;
                idx++;
            end
            wait_drain();
            report_test(test_id, errors_at_start);
        end

        $display("tests passed %0d, tests failed %0d, total mismatches %0d",
                 tests_passed, tests_failed, errors);
        if (errors == 0) begin
            $display("No errors");
        end else begin
            $display("Errors found");
        end
        $finish;
    end

    // budget grows with the stimulus length
    initial begin
        int limit_cycles;
        #1;
        limit_cycles = line_count * (`MUL_STAGES + 8);
        #(limit_cycles * 10);
        $display("watchdog expired after %0d cycles, the run did not finish", limit_cycles);
        $display("Errors found");
        $finish;
    end

endmodule

`default_nettype wire
